// File: rtl/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    localparam int XLEN   = 32; // data and pc width
    localparam int REG_AW = 5;  // register address width
    localparam int LANES  = 2;  // issue width

    typedef logic [7:0] alu_op_t;
    typedef logic [2:0] alu_sel_t;

    // alu ops this stage has to recognise
    localparam alu_op_t ALU_PCADDU12I = 8'h1c;
    localparam alu_op_t ALU_LDB       = 8'h28; // load class
    localparam alu_op_t ALU_LDH       = 8'h29;
    localparam alu_op_t ALU_LDW       = 8'h2a;
    localparam alu_op_t ALU_LDBU      = 8'h2c;
    localparam alu_op_t ALU_LDHU      = 8'h2d;
    localparam alu_op_t ALU_LLW       = 8'h30;
    localparam alu_op_t ALU_SCW       = 8'h31; // sc.w returns data too

    localparam alu_sel_t ALU_SEL_LOAD_STORE = 3'b111;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        alu_op_t           alu_op;
        alu_sel_t          alu_sel;
        logic [XLEN-1:0]   imm;
        logic              src1_en;
        logic [REG_AW-1:0] src1_addr;
        logic              src2_en;
        logic [REG_AW-1:0] src2_addr;
        logic              rd_en;
        logic [REG_AW-1:0] rd_addr;
        logic              is_priv;
        logic              is_cnt;
    } inst_slot_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_port_t;

    typedef struct packed {
        wb_port_t port0; // older of the pair, wins on a tie
        wb_port_t port1;
    } fwd_stage_t;

    typedef struct packed {
        logic [XLEN-1:0] data1;
        logic [XLEN-1:0] data2;
    } rf_read_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        alu_op_t           alu_op;
        alu_sel_t          alu_sel;
        logic              rd_en;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   src1_val;
        logic [XLEN-1:0]   src2_val;
    } issue_slot_t;

    // ops whose result only exists after the memory stage
    function automatic logic is_load_op(input alu_op_t op);
        return (op == ALU_LDB) || (op == ALU_LDH) || (op == ALU_LDW)
            || (op == ALU_LDBU) || (op == ALU_LDHU) || (op == ALU_LLW)
            || (op == ALU_SCW);
    endfunction

endpackage

`default_nettype wire

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
    input  var dispatch_pkg::inst_slot_t [dispatch_pkg::LANES-1:0] slot_i,
    input  var logic [dispatch_pkg::REG_AW-1:0]                     ex_wr_addr_i,
    input  var dispatch_pkg::alu_op_t [1:0]                         ex_alu_op_i,
    input  var logic                                                ex_pause_i,
    output var logic [dispatch_pkg::LANES-1:0]                      send_en_o,
    output var logic                                                stall_o
);

    logic mem_inst;     // either slot goes to the load/store unit
    logic priv_inst;
    logic cnt_inst;
    logic raw_hazard;   // slot 1 reads what slot 0 writes
    logic send_double;
    logic ex_load;
    logic [3:0] ex_match; // one bit per enabled source

    assign mem_inst = (slot_i[0].alu_sel == dispatch_pkg::ALU_SEL_LOAD_STORE)
                   || (slot_i[1].alu_sel == dispatch_pkg::ALU_SEL_LOAD_STORE);
    assign priv_inst = slot_i[0].is_priv || slot_i[1].is_priv;
    assign cnt_inst  = slot_i[0].is_cnt || slot_i[1].is_cnt;

    // writes to r0 are dropped, so they never create a dependency
    assign raw_hazard = slot_i[0].rd_en && (slot_i[0].rd_addr != '0)
        && ((slot_i[1].src1_en && (slot_i[1].src1_addr == slot_i[0].rd_addr))
         || (slot_i[1].src2_en && (slot_i[1].src2_addr == slot_i[0].rd_addr)));

    assign send_double = slot_i[0].valid && slot_i[1].valid && !mem_inst
                      && !priv_inst && !cnt_inst && !raw_hazard;

    always_comb begin
        if (send_double) begin
            send_en_o = 2'b11;
        end else if (slot_i[0].valid) begin
            send_en_o = 2'b01; // older slot first
        end else if (slot_i[1].valid) begin
            send_en_o = 2'b10;
        end else begin
            send_en_o = 2'b00;
        end
    end

    assign ex_load = dispatch_pkg::is_load_op(ex_alu_op_i[0])
                  || dispatch_pkg::is_load_op(ex_alu_op_i[1]);

    // loads are never paired, so only ex port 0 can hold the load target
    assign ex_match[0] = slot_i[0].src1_en && (slot_i[0].src1_addr == ex_wr_addr_i);
    assign ex_match[1] = slot_i[0].src2_en && (slot_i[0].src2_addr == ex_wr_addr_i);
    assign ex_match[2] = slot_i[1].src1_en && (slot_i[1].src1_addr == ex_wr_addr_i);
    assign ex_match[3] = slot_i[1].src2_en && (slot_i[1].src2_addr == ex_wr_addr_i);

    assign stall_o = ex_load && (|ex_match) && !ex_pause_i;

endmodule

`default_nettype wire

// File: rtl/operand_lane.sv
`timescale 1ns/1ps
`default_nettype none

module operand_lane (
    input  var dispatch_pkg::inst_slot_t  slot_i,
    input  var dispatch_pkg::rf_read_t    rf_i,
    input  var logic                      send_i,
    input  var dispatch_pkg::fwd_stage_t  ex_fwd_i,
    input  var dispatch_pkg::fwd_stage_t  mem_fwd_i,
    input  var dispatch_pkg::fwd_stage_t  wb_fwd_i,
    output var dispatch_pkg::issue_slot_t issue_o
);

    logic                         is_pcadd;
    logic [dispatch_pkg::XLEN-1:0] src1_val;
    logic [dispatch_pkg::XLEN-1:0] src2_val;

    // one stage's two write ports, port0 first
    function automatic logic [dispatch_pkg::XLEN-1:0] pick_fwd(
        input dispatch_pkg::fwd_stage_t      st,
        input logic [dispatch_pkg::REG_AW-1:0] addr,
        input logic [dispatch_pkg::XLEN-1:0]   prev
    );
        if (st.port0.en && (st.port0.addr == addr)) begin
            return st.port0.data;
        end else if (st.port1.en && (st.port1.addr == addr)) begin
            return st.port1.data;
        end
        return prev;
    endfunction

    function automatic logic [dispatch_pkg::XLEN-1:0] resolve_src(
        input logic                          en,
        input logic [dispatch_pkg::REG_AW-1:0] addr,
        input logic [dispatch_pkg::XLEN-1:0]   rf_data
    );
        logic [dispatch_pkg::XLEN-1:0] val;

        val = en ? rf_data : slot_i.imm; // disabled source carries the immediate
        if (en) begin
            // applied oldest first so the youngest producer wins
            val = pick_fwd(wb_fwd_i, addr, val);
            val = pick_fwd(mem_fwd_i, addr, val);
            val = pick_fwd(ex_fwd_i, addr, val);
            if (addr == '0) begin
                val = '0;
            end
            if (is_pcadd) begin
                val = slot_i.pc;
            end
        end
        return val;
    endfunction

    assign is_pcadd = (slot_i.alu_op == dispatch_pkg::ALU_PCADDU12I);

    always_comb begin
        src1_val = resolve_src(slot_i.src1_en, slot_i.src1_addr, rf_i.data1);
        src2_val = resolve_src(slot_i.src2_en, slot_i.src2_addr, rf_i.data2);
    end

    always_comb begin
        issue_o = '0; // unsent lane leaves as a bubble
        if (send_i) begin
            issue_o.valid    = slot_i.valid;
            issue_o.pc       = slot_i.pc;
            issue_o.inst     = slot_i.inst;
            issue_o.alu_op   = slot_i.alu_op;
            issue_o.alu_sel  = slot_i.alu_sel;
            issue_o.rd_en    = slot_i.rd_en;
            issue_o.rd_addr  = slot_i.rd_addr;
            issue_o.src1_val = src1_val;
            issue_o.src2_val = src2_val;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dispatch_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_reg (
    input  var logic                                                 clk,
    input  var logic                                                 rst_n_i,
    input  var logic                                                 flush_i,
    input  var logic                                                 pause_i,
    input  var logic                                                 stall_i,
    input  var logic [dispatch_pkg::LANES-1:0]                       send_en_i,
    input  var dispatch_pkg::issue_slot_t [dispatch_pkg::LANES-1:0]  lane_i,
    output var logic [dispatch_pkg::LANES-1:0]                       issue_o,
    output var dispatch_pkg::issue_slot_t [dispatch_pkg::LANES-1:0]  out_o
);

    dispatch_pkg::issue_slot_t [dispatch_pkg::LANES-1:0] out_q;

    // decode only retires what was really taken this cycle
    assign issue_o = pause_i ? '0 : send_en_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || stall_i) begin
            out_q <= '0; // bubble toward execute
        end else if (!pause_i) begin
            out_q <= lane_i;
        end
    end

    assign out_o = out_q;

endmodule

`default_nettype wire

// File: rtl/dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
    input  var logic                                                 clk,
    input  var logic                                                 rst_n_i,
    input  var dispatch_pkg::inst_slot_t [dispatch_pkg::LANES-1:0]   slot_i,
    input  var dispatch_pkg::rf_read_t [dispatch_pkg::LANES-1:0]     rf_i,
    input  var dispatch_pkg::fwd_stage_t                             ex_fwd_i,
    input  var dispatch_pkg::fwd_stage_t                             mem_fwd_i,
    input  var dispatch_pkg::fwd_stage_t                             wb_fwd_i,
    input  var dispatch_pkg::alu_op_t [1:0]                          ex_alu_op_i,
    input  var logic                                                 ex_pause_i,
    input  var logic                                                 pause_i,
    input  var logic                                                 flush_i,
    output var logic [dispatch_pkg::LANES-1:0]                       issue_o,
    output var logic                                                 stall_o,
    output var dispatch_pkg::issue_slot_t [dispatch_pkg::LANES-1:0]  out_o
);

    logic [dispatch_pkg::LANES-1:0]                      send_en;
    logic                                                stall;
    dispatch_pkg::issue_slot_t [dispatch_pkg::LANES-1:0] lane_slot;

    issue_ctrl u_issue_ctrl (
        .slot_i       (slot_i),
        .ex_wr_addr_i (ex_fwd_i.port0.addr), // load target sits on port 0
        .ex_alu_op_i  (ex_alu_op_i),
        .ex_pause_i   (ex_pause_i),
        .send_en_o    (send_en),
        .stall_o      (stall)
    );

    assign stall_o = stall;

    for (genvar g = 0; g < dispatch_pkg::LANES; g++) begin : g_lane
        operand_lane u_operand_lane (
            .slot_i    (slot_i[g]),
            .rf_i      (rf_i[g]),
            .send_i    (send_en[g]),
            .ex_fwd_i  (ex_fwd_i),
            .mem_fwd_i (mem_fwd_i),
            .wb_fwd_i  (wb_fwd_i),
            .issue_o   (lane_slot[g])
        );
    end

    dispatch_reg u_dispatch_reg (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .pause_i   (pause_i),
        .stall_i   (stall),
        .send_en_i (send_en),
        .lane_i    (lane_slot),
        .issue_o   (issue_o),
        .out_o     (out_o)
    );

endmodule

`default_nettype wire

// File: tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output var logic clk_o,
    output var logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o); // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/tb_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch;

    localparam int RANDOM_CYCLES = 600;
    localparam int MAX_CYCLES    = 1000; // reset + ~20 directed + random run, with margin

    logic                            clk;
    logic                            rst_n;
    dispatch_pkg::inst_slot_t [1:0]  slot;
    dispatch_pkg::rf_read_t [1:0]    rf;
    dispatch_pkg::fwd_stage_t        ex_fwd;
    dispatch_pkg::fwd_stage_t        mem_fwd;
    dispatch_pkg::fwd_stage_t        wb_fwd;
    dispatch_pkg::alu_op_t [1:0]     ex_alu_op;
    logic                            ex_pause;
    logic                            pause;
    logic                            flush;
    logic [1:0]                      issue;
    logic                            stall;
    dispatch_pkg::issue_slot_t [1:0] out;

    dispatch_pkg::issue_slot_t [1:0] model_out; // expected register contents
    logic                            model_ok = 1'b0;
    logic [1:0]                      send_exp;
    logic                            stall_exp;
    int                              errors = 0;
    int                              checks = 0;
    int                              cycles = 0;

    clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dispatch_top u_dispatch_top (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .slot_i      (slot),
        .rf_i        (rf),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .wb_fwd_i    (wb_fwd),
        .ex_alu_op_i (ex_alu_op),
        .ex_pause_i  (ex_pause),
        .pause_i     (pause),
        .flush_i     (flush),
        .issue_o     (issue),
        .stall_o     (stall),
        .out_o       (out)
    );

    task automatic check_cond(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("FAILED t=%0t: %s", $time, msg);
        end
    endtask

    function automatic logic is_load_class(input dispatch_pkg::alu_op_t op);
        return op inside {dispatch_pkg::ALU_LDB, dispatch_pkg::ALU_LDH, dispatch_pkg::ALU_LDW,
                          dispatch_pkg::ALU_LDBU, dispatch_pkg::ALU_LDHU, dispatch_pkg::ALU_LLW,
                          dispatch_pkg::ALU_SCW};
    endfunction

    function automatic logic [1:0] expect_send(input dispatch_pkg::inst_slot_t [1:0] s);
        logic dep;
        logic pair_ok;
        dep = s[0].rd_en && (s[0].rd_addr != 5'd0)
            && ((s[1].src1_en && (s[1].src1_addr == s[0].rd_addr))
             || (s[1].src2_en && (s[1].src2_addr == s[0].rd_addr)));
        pair_ok = s[0].valid && s[1].valid && !dep
            && (s[0].alu_sel != dispatch_pkg::ALU_SEL_LOAD_STORE)
            && (s[1].alu_sel != dispatch_pkg::ALU_SEL_LOAD_STORE)
            && !(s[0].is_priv || s[1].is_priv || s[0].is_cnt || s[1].is_cnt);
        if (pair_ok) begin
            return 2'b11;
        end
        if (s[0].valid) begin
            return 2'b01; // oldest valid slot goes alone
        end
        if (s[1].valid) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    function automatic logic expect_stall();
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 2; i++) begin
            hit |= slot[i].src1_en && (slot[i].src1_addr == ex_fwd.port0.addr);
            hit |= slot[i].src2_en && (slot[i].src2_addr == ex_fwd.port0.addr);
        end
        return hit && !ex_pause && (is_load_class(ex_alu_op[0]) || is_load_class(ex_alu_op[1]));
    endfunction

    function automatic logic stage_hit(input dispatch_pkg::fwd_stage_t st,
                                       input logic [4:0] addr, output logic [31:0] val);
        val = '0;
        if (st.port0.en && (st.port0.addr == addr)) begin
            val = st.port0.data;
            return 1'b1;
        end
        if (st.port1.en && (st.port1.addr == addr)) begin
            val = st.port1.data;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] expect_src(input dispatch_pkg::inst_slot_t s, input logic en,
                                               input logic [4:0] addr, input logic [31:0] rf_val);
        logic [31:0] fwd_val;
        if (!en) begin
            return s.imm;
        end
        if (s.alu_op == dispatch_pkg::ALU_PCADDU12I) begin
            return s.pc;
        end
        if (addr == 5'd0) begin
            return '0;
        end
        if (stage_hit(ex_fwd, addr, fwd_val)) begin
            return fwd_val; // youngest producer first
        end
        if (stage_hit(mem_fwd, addr, fwd_val)) begin
            return fwd_val;
        end
        if (stage_hit(wb_fwd, addr, fwd_val)) begin
            return fwd_val;
        end
        return rf_val;
    endfunction

    function automatic dispatch_pkg::issue_slot_t expect_lane(input int i, input logic sent);
        dispatch_pkg::issue_slot_t e;
        e = '0;
        if (sent) begin
            e.valid    = slot[i].valid;
            e.pc       = slot[i].pc;
            e.inst     = slot[i].inst;
            e.alu_op   = slot[i].alu_op;
            e.alu_sel  = slot[i].alu_sel;
            e.rd_en    = slot[i].rd_en;
            e.rd_addr  = slot[i].rd_addr;
            e.src1_val = expect_src(slot[i], slot[i].src1_en, slot[i].src1_addr, rf[i].data1);
            e.src2_val = expect_src(slot[i], slot[i].src2_en, slot[i].src2_addr, rf[i].data2);
        end
        return e;
    endfunction

    // inputs settle at the falling edge, so the rising edge sees them stable
    always @(posedge clk) begin
        send_exp  = expect_send(slot);
        stall_exp = expect_stall();
        check_cond(issue == (pause ? 2'b00 : send_exp),
                   $sformatf("issue_o %b, expected %b", issue, pause ? 2'b00 : send_exp));
        check_cond(stall == stall_exp, $sformatf("stall_o %b, expected %b", stall, stall_exp));
        if (!rst_n || flush || stall_exp) begin
            model_out = '0;
        end else if (!pause) begin
            model_out[0] = expect_lane(0, send_exp[0]);
            model_out[1] = expect_lane(1, send_exp[1]);
        end
        model_ok = 1'b1;
    end

    always @(negedge clk) begin
        if (model_ok) begin
            for (int i = 0; i < 2; i++) begin
                check_cond((out[i].valid == model_out[i].valid)
                           && (out[i].rd_en == model_out[i].rd_en),
                           $sformatf("lane %0d valid/rd_en %b%b, expected %b%b", i,
                                     out[i].valid, out[i].rd_en,
                                     model_out[i].valid, model_out[i].rd_en));
                check_cond(out[i].src1_val == model_out[i].src1_val,
                           $sformatf("lane %0d src1 %h, expected %h", i,
                                     out[i].src1_val, model_out[i].src1_val));
                check_cond(out[i].src2_val == model_out[i].src2_val,
                           $sformatf("lane %0d src2 %h, expected %h", i,
                                     out[i].src2_val, model_out[i].src2_val));
                check_cond(out[i] == model_out[i], $sformatf("lane %0d slot fields differ", i));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic dispatch_pkg::wb_port_t make_port(input logic [4:0] addr,
                                                         input logic [31:0] data);
        dispatch_pkg::wb_port_t p;
        p.en   = 1'b1;
        p.addr = addr;
        p.data = data;
        return p;
    endfunction

    function automatic dispatch_pkg::inst_slot_t plain_slot(input logic [4:0] a1,
                                                            input logic [4:0] a2);
        dispatch_pkg::inst_slot_t s;
        s           = '0;
        s.valid     = 1'b1;
        s.pc        = $urandom;
        s.inst      = $urandom;
        s.alu_op    = 8'h10; // plain alu op
        s.imm       = 32'h0000_0abc;
        s.src1_en   = 1'b1;
        s.src1_addr = a1;
        s.src2_en   = 1'b1;
        s.src2_addr = a2;
        s.rd_en     = 1'b1;
        s.rd_addr   = 5'd5;
        return s;
    endfunction

    function automatic dispatch_pkg::inst_slot_t random_slot();
        dispatch_pkg::inst_slot_t s;
        s           = plain_slot(5'($urandom_range(3, 0)), 5'($urandom_range(3, 0)));
        s.valid     = ($urandom_range(3, 0) != 0);
        s.src1_en   = ($urandom_range(3, 0) != 0);
        s.src2_en   = ($urandom_range(3, 0) != 0);
        s.rd_en     = ($urandom_range(3, 0) != 0);
        s.rd_addr   = 5'($urandom_range(3, 0)); // small range, frequent collisions
        s.imm       = $urandom;
        s.alu_op    = ($urandom_range(4, 0) == 0) ? dispatch_pkg::ALU_PCADDU12I : 8'h10;
        s.alu_sel   = ($urandom_range(4, 0) == 0) ? dispatch_pkg::ALU_SEL_LOAD_STORE
                                                  : 3'($urandom_range(3, 0));
        s.is_priv   = ($urandom_range(15, 0) == 0);
        s.is_cnt    = ($urandom_range(15, 0) == 0);
        return s;
    endfunction

    function automatic dispatch_pkg::fwd_stage_t random_stage();
        dispatch_pkg::fwd_stage_t st;
        st.port0    = make_port(5'($urandom_range(3, 0)), $urandom);
        st.port1    = make_port(5'($urandom_range(3, 0)), $urandom);
        st.port0.en = ($urandom_range(1, 0) != 0);
        st.port1.en = ($urandom_range(1, 0) != 0);
        return st;
    endfunction

    // every load-class op shows up, about half the time per port
    function automatic dispatch_pkg::alu_op_t random_ex_op();
        case ($urandom_range(13, 0))
            0: return dispatch_pkg::ALU_LDB;
            1: return dispatch_pkg::ALU_LDH;
            2: return dispatch_pkg::ALU_LDW;
            3: return dispatch_pkg::ALU_LDBU;
            4: return dispatch_pkg::ALU_LDHU;
            5: return dispatch_pkg::ALU_LLW;
            6: return dispatch_pkg::ALU_SCW;
            default: return 8'h10;
        endcase
    endfunction

    task automatic clear_inputs();
        slot      = '0;
        rf        = '0;
        ex_fwd    = '0;
        mem_fwd   = '0;
        wb_fwd    = '0;
        ex_alu_op = '0;
        ex_pause  = 1'b0;
        pause     = 1'b0;
        flush     = 1'b0;
    endtask

    task automatic randomize_inputs();
        slot[0]      = random_slot();
        slot[1]      = random_slot();
        rf[0]        = {$urandom, $urandom};
        rf[1]        = {$urandom, $urandom};
        ex_fwd       = random_stage();
        mem_fwd      = random_stage();
        wb_fwd       = random_stage();
        ex_alu_op[0] = random_ex_op();
        ex_alu_op[1] = random_ex_op();
        ex_pause     = ($urandom_range(3, 0) == 0);
        pause        = ($urandom_range(7, 0) == 0);
        flush        = ($urandom_range(15, 0) == 0);
    endtask

    initial begin
        void'($urandom(32'h59ab_3de2));
        clear_inputs();
        wait (rst_n === 1'b1);
        repeat (3) @(negedge clk); // idle after reset, nothing valid yet
        @(negedge clk);
        slot[0]       = plain_slot(5'd2, 5'd2);
        ex_fwd.port1  = make_port(5'd2, 32'h0000_00e1); // ex beats mem and wb
        mem_fwd.port0 = make_port(5'd2, 32'h0000_00d0);
        wb_fwd.port0  = make_port(5'd2, 32'h0000_00b0);
        @(negedge clk);
        clear_inputs();
        slot[0]       = plain_slot(5'd2, 5'd0);
        mem_fwd.port1 = make_port(5'd2, 32'h0000_00d1);
        mem_fwd.port0 = make_port(5'd0, 32'h0000_0bad); // r0 stays zero
        wb_fwd.port0  = make_port(5'd2, 32'h0000_00b0);
        @(negedge clk);
        clear_inputs();
        slot[0]         = plain_slot(5'd1, 5'd3);
        slot[0].alu_op  = dispatch_pkg::ALU_PCADDU12I;
        slot[0].src2_en = 1'b0; // takes the immediate
        slot[1]         = plain_slot(5'd3, 5'd1);
        @(negedge clk);
        clear_inputs();
        slot[0]      = plain_slot(5'd3, 5'd1);
        ex_alu_op[0] = dispatch_pkg::ALU_LDW; // load-use on r3
        ex_fwd.port0 = make_port(5'd3, 32'h0000_0333);
        @(negedge clk);
        clear_inputs();
        slot[0] = plain_slot(5'd1, 5'd2);
        slot[1] = plain_slot(5'd3, 5'd1);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
        slot[0].pc = 32'h0000_4000;
        pause      = 1'b1; // register holds
        repeat (2) @(negedge clk);
        clear_inputs();
        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            randomize_inputs();
        end
        @(negedge clk);
        clear_inputs();
        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/dispatch_pkg.sv
rtl/issue_ctrl.sv
rtl/operand_lane.sv
rtl/dispatch_reg.sv
rtl/dispatch_top.sv
tests/clk_gen.sv
tests/tb_dispatch.sv
